//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
hw/rv32i_pkg.sv
hw/rv32i_decoder.sv
hw/rv32i_imm_gen.sv
hw/rv32i_regfile.sv
hw/rv32i_id_ex_reg.sv
hw/rv32i_decode_stage.sv
sim/tb_decode_stage.sv

//--- hw/rv32i_decode_stage.sv
`timescale 1ns/1ns

module rv32i_decode_stage (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_valid,
    input  logic [rv32i_pkg::XLEN-1:0]       i_instr,
    input  logic [rv32i_pkg::XLEN-1:0]       i_pc,
    input  logic                             i_bubble,
    input  logic                             i_stall,
    input  logic                             i_wb_we,
    input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [rv32i_pkg::XLEN-1:0]       i_wb_data,
    output logic                             o_ex_valid,
    output logic [rv32i_pkg::XLEN-1:0]       o_ex_pc,
    output logic [rv32i_pkg::CW_W-1:0]       o_ex_cw,
    output logic [2:0]                       o_ex_branch_sel,
    output logic [rv32i_pkg::XLEN-1:0]       o_ex_imm,
    output logic [rv32i_pkg::XLEN-1:0]       o_ex_rs1_data,
    output logic [rv32i_pkg::XLEN-1:0]       o_ex_rs2_data
);

    import rv32i_pkg::*;

    logic [CW_W-1:0]       cw;
    logic [2:0]            branch_sel;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    assign rs1_addr = cw[CW_ASEL_LSB +: REG_ADDR_W];    // Zero for U/J and bubbles
    assign rs2_addr = cw[CW_BSEL_LSB +: REG_ADDR_W];

    rv32i_decoder u_decoder (
        .i_instr        (i_instr),
        .i_bubble       (i_bubble),
        .o_control_word (cw),
        .o_branch_sel   (branch_sel)
    );

    rv32i_imm_gen u_imm_gen (
        .i_instr (i_instr),
        .o_imm   (imm)
    );

    rv32i_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_we      (i_wb_we),
        .i_waddr   (i_wb_addr),
        .i_wdata   (i_wb_data),
        .i_raddr_a (rs1_addr),
        .i_raddr_b (rs2_addr),
        .o_rdata_a (rs1_data),
        .o_rdata_b (rs2_data)
    );

    rv32i_id_ex_reg u_id_ex_reg (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_stall         (i_stall),
        .i_valid         (i_valid),
        .i_bubble        (i_bubble),
        .i_pc            (i_pc),
        .i_cw            (cw),
        .i_branch_sel    (branch_sel),
        .i_imm           (imm),
        .i_rs1_data      (rs1_data),
        .i_rs2_data      (rs2_data),
        .o_ex_valid      (o_ex_valid),
        .o_ex_pc         (o_ex_pc),
        .o_ex_cw         (o_ex_cw),
        .o_ex_branch_sel (o_ex_branch_sel),
        .o_ex_imm        (o_ex_imm),
        .o_ex_rs1_data   (o_ex_rs1_data),
        .o_ex_rs2_data   (o_ex_rs2_data)
    );

endmodule

//--- hw/rv32i_decoder.sv
`timescale 1ns/1ns

module rv32i_decoder (
    input  logic [rv32i_pkg::XLEN-1:0] i_instr,
    input  logic                       i_bubble,
    output logic [rv32i_pkg::CW_W-1:0] o_control_word,
    output logic [2:0]                 o_branch_sel
);

    import rv32i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       r_type;
    logic       i_type;
    logic       s_type;
    logic       b_type;
    logic       u_type;
    logic       j_type;
    logic       known_op;
    logic       load;
    logic       jalr;
    logic       save_pc;
    logic       we;
    logic       use_immediate;
    logic [3:0] function_select;
    logic [2:0] mem_width;
    logic [2:0] branch_sel;
    logic [REG_ADDR_W-1:0] d_addr;
    logic [REG_ADDR_W-1:0] a_select;
    logic [REG_ADDR_W-1:0] b_select;
    logic [CW_W-1:0]       cw_raw;

    assign opcode = i_instr[6:0];
    assign func3  = i_instr[14:12];

    always_comb
    begin
        r_type  = 1'b0;
        i_type  = 1'b0;
        s_type  = 1'b0;
        b_type  = 1'b0;
        u_type  = 1'b0;
        j_type  = 1'b0;
        load    = 1'b0;
        jalr    = 1'b0;
        save_pc = 1'b0;
        case (opcode)
            OPC_OP:     r_type = 1'b1;
            OPC_OP_IMM: i_type = 1'b1;
            OPC_LOAD:
            begin
                i_type = 1'b1;
                load   = 1'b1;
            end
            OPC_JALR:                               // Jump register, links PC
            begin
                i_type  = 1'b1;
                jalr    = 1'b1;
                save_pc = 1'b1;
            end
            OPC_STORE:  s_type = 1'b1;
            OPC_BRANCH: b_type = 1'b1;
            OPC_LUI:    u_type = 1'b1;
            OPC_AUIPC:
            begin
                u_type  = 1'b1;
                save_pc = 1'b1;
            end
            OPC_JAL:
            begin
                j_type  = 1'b1;
                save_pc = 1'b1;
            end
            default: ;                              // Unknown opcode, all zero
        endcase
    end

    assign known_op      = r_type | i_type | s_type | b_type | u_type | j_type;
    assign use_immediate = i_type | s_type | u_type | j_type;
    assign we            = r_type | i_type | u_type | j_type;
    assign d_addr        = we ? i_instr[11:7] : '0;
    assign a_select      = (known_op && !(u_type || j_type)) ? i_instr[19:15] : '0;
    assign b_select      = known_op ? i_instr[24:20] : '0;
    assign mem_width     = (s_type || load) ? func3 : 3'd0;

    always_comb
    begin
        if (jalr)
            branch_sel = BR_JALR;
        else if (j_type)
            branch_sel = BR_JAL;
        else if (b_type)
        begin
            case (func3)
                3'b000:  branch_sel = BR_EQ;
                3'b001:  branch_sel = BR_NE;
                3'b100:  branch_sel = BR_LT;
                3'b101:  branch_sel = BR_GE;
                3'b110:  branch_sel = BR_LT;        // BLTU
                3'b111:  branch_sel = BR_GE;        // BGEU
                default: branch_sel = BR_NONE;
            endcase
        end
        else
            branch_sel = BR_NONE;
    end

    always_comb
    begin
        function_select = ALU_ADD;                  // Loads, stores, jumps, U-type
        if ((r_type || i_type) && !(load || jalr))
        begin
            case (func3)
                3'b000:  function_select = (r_type && i_instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  function_select = ALU_SLL;
                3'b010:  function_select = ALU_SLT;
                3'b011:  function_select = ALU_SLTU;
                3'b100:  function_select = ALU_XOR;
                3'b101:  function_select = i_instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  function_select = ALU_OR;
                default: function_select = ALU_AND;
            endcase
        end
        else if (b_type)
            function_select = (func3[2:1] == 2'b11) ? ALU_SLTU : ALU_SUB;
    end

    always_comb
    begin
        cw_raw                                 = '0;
        cw_raw[CW_DADDR_LSB +: REG_ADDR_W]     = d_addr;
        cw_raw[CW_BSEL_LSB +: REG_ADDR_W]      = b_select;
        cw_raw[CW_ASEL_LSB +: REG_ADDR_W]      = a_select;
        cw_raw[CW_FUNC_LSB +: 4]               = function_select;
        cw_raw[CW_WE_BIT]                      = we;
        cw_raw[CW_SAVEPC_BIT]                  = save_pc;
        cw_raw[CW_LOAD_BIT]                    = load;
        cw_raw[CW_USEIMM_BIT]                  = use_immediate;
        cw_raw[CW_MEMW_LSB +: 3]               = mem_width;
    end

    assign o_control_word = i_bubble ? '0 : cw_raw;
    assign o_branch_sel   = i_bubble ? BR_NONE : branch_sel;

endmodule

//--- hw/rv32i_id_ex_reg.sv
`timescale 1ns/1ns

module rv32i_id_ex_reg (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_stall,
    input  logic                       i_valid,
    input  logic                       i_bubble,
    input  logic [rv32i_pkg::XLEN-1:0] i_pc,
    input  logic [rv32i_pkg::CW_W-1:0] i_cw,
    input  logic [2:0]                 i_branch_sel,
    input  logic [rv32i_pkg::XLEN-1:0] i_imm,
    input  logic [rv32i_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv32i_pkg::XLEN-1:0] i_rs2_data,
    output logic                       o_ex_valid,
    output logic [rv32i_pkg::XLEN-1:0] o_ex_pc,
    output logic [rv32i_pkg::CW_W-1:0] o_ex_cw,
    output logic [2:0]                 o_ex_branch_sel,
    output logic [rv32i_pkg::XLEN-1:0] o_ex_imm,
    output logic [rv32i_pkg::XLEN-1:0] o_ex_rs1_data,
    output logic [rv32i_pkg::XLEN-1:0] o_ex_rs2_data
);

    import rv32i_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ex_valid      <= 1'b0;
            o_ex_pc         <= '0;
            o_ex_cw         <= '0;
            o_ex_branch_sel <= BR_NONE;
            o_ex_imm        <= '0;
            o_ex_rs1_data   <= '0;
            o_ex_rs2_data   <= '0;
        end
        else if (!i_stall)                      // Stall holds the stage
        begin
            o_ex_valid      <= i_valid & ~i_bubble;
            o_ex_pc         <= i_pc;
            o_ex_cw         <= i_cw;
            o_ex_branch_sel <= i_branch_sel;
            o_ex_imm        <= i_imm;
            o_ex_rs1_data   <= i_rs1_data;
            o_ex_rs2_data   <= i_rs2_data;
        end
    end

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stall |=> ($stable(o_ex_valid) && $stable(o_ex_pc) && $stable(o_ex_cw) &&
                     $stable(o_ex_branch_sel) && $stable(o_ex_imm) &&
                     $stable(o_ex_rs1_data) && $stable(o_ex_rs2_data)));

endmodule

//--- hw/rv32i_imm_gen.sv
`timescale 1ns/1ns

module rv32i_imm_gen (
    input  logic [rv32i_pkg::XLEN-1:0] i_instr,
    output logic [rv32i_pkg::XLEN-1:0] o_imm
);

    import rv32i_pkg::*;

    logic [6:0] opcode;
    logic       sign;

    assign opcode = i_instr[6:0];
    assign sign   = i_instr[31];

    always_comb
    begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:         // I format
                o_imm = {{20{sign}}, i_instr[31:20]};
            OPC_STORE:                              // S format
                o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            OPC_BRANCH:                             // B format, halfword aligned
                o_imm = {{19{sign}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:                     // Upper 20 bits
                o_imm = {i_instr[31:12], 12'd0};
            OPC_JAL:                                // J format
                o_imm = {{11{sign}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            default:
                o_imm = '0;                         // R-type and unknown
        endcase
    end

endmodule

//--- hw/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CW_W       = 26;

    // Control word layout
    localparam int CW_DADDR_LSB  = 21;             // d_addr 25:21
    localparam int CW_BSEL_LSB   = 16;             // b_select 20:16
    localparam int CW_ASEL_LSB   = 11;             // a_select 15:11
    localparam int CW_FUNC_LSB   = 7;              // function_select 10:7
    localparam int CW_WE_BIT     = 6;
    localparam int CW_SAVEPC_BIT = 5;
    localparam int CW_LOAD_BIT   = 4;
    localparam int CW_USEIMM_BIT = 3;
    localparam int CW_MEMW_LSB   = 0;              // mem_width 2:0

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLT  = 4'd2;
    localparam logic [3:0] ALU_SLTU = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_OR   = 4'd5;
    localparam logic [3:0] ALU_AND  = 4'd6;
    localparam logic [3:0] ALU_SLL  = 4'd8;
    localparam logic [3:0] ALU_SRA  = 4'd9;
    localparam logic [3:0] ALU_SRL  = 4'd10;

    // Unsigned compares reuse LT/GE, the ALU code picks signedness
    localparam logic [2:0] BR_NONE = 3'd0;
    localparam logic [2:0] BR_EQ   = 3'd2;
    localparam logic [2:0] BR_NE   = 3'd3;
    localparam logic [2:0] BR_LT   = 3'd4;
    localparam logic [2:0] BR_GE   = 3'd5;
    localparam logic [2:0] BR_JAL  = 3'd6;
    localparam logic [2:0] BR_JALR = 3'd7;

endpackage

//--- hw/rv32i_regfile.sv
`timescale 1ns/1ns

module rv32i_regfile (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_we,
    input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_waddr,
    input  logic [rv32i_pkg::XLEN-1:0]       i_wdata,
    input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_raddr_a,
    input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_raddr_b,
    output logic [rv32i_pkg::XLEN-1:0]       o_rdata_a,
    output logic [rv32i_pkg::XLEN-1:0]       o_rdata_b
);

    import rv32i_pkg::*;

    logic [XLEN-1:0]       regs [1:31];         // x0 has no storage
    logic [REG_ADDR_W-1:0] raddr [2];
    logic [XLEN-1:0]       rdata [2];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int r = 1; r < 32; r++)
                regs[r] <= '0;
        end
        else if (i_we && i_waddr != '0)
            regs[i_waddr] <= i_wdata;
    end

    assign raddr[0] = i_raddr_a;
    assign raddr[1] = i_raddr_b;

    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (raddr[p] == '0)
                rdata[p] = '0;
            else if (i_we && raddr[p] == i_waddr)
                rdata[p] = i_wdata;             // Write-through from writeback
            else
                rdata[p] = regs[raddr[p]];
        end
    end

    assign o_rdata_a = rdata[0];
    assign o_rdata_b = rdata[1];

    // Written data reads back on port A from the next cycle on
    a_write_visible: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_we && i_waddr != '0) |=>
            (i_raddr_a != $past(i_waddr) || (i_we && i_waddr == i_raddr_a) ||
             o_rdata_a == $past(i_wdata)));

endmodule

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;

    import rv32i_pkg::*;

    localparam logic [31:0] NOP_INSTR = {12'd0, 5'd0, 3'd0, 5'd0, OPC_OP_IMM};

    logic              clk;
    logic              rst_n;
    logic              valid;
    logic [31:0]       instr;
    logic [31:0]       pc;
    logic              bubble;
    logic              stall;
    logic              wb_we;
    logic [4:0]        wb_addr;
    logic [31:0]       wb_data;
    logic              ex_valid;
    logic [31:0]       ex_pc;
    logic [CW_W-1:0]   ex_cw;
    logic [2:0]        ex_bsel;
    logic [31:0]       ex_imm;
    logic [31:0]       ex_rs1;
    logic [31:0]       ex_rs2;

    // Expected outputs now (cur) and after the coming edge (nxt)
    logic              cur_chk;
    logic              cur_valid;
    logic [31:0]       cur_pc;
    logic [CW_W-1:0]   cur_cw;
    logic [2:0]        cur_bsel;
    logic [31:0]       cur_imm;
    logic [31:0]       cur_rs1;
    logic [31:0]       cur_rs2;
    logic              nxt_valid;
    logic [31:0]       nxt_pc;
    logic [CW_W-1:0]   nxt_cw;
    logic [2:0]        nxt_bsel;
    logic [31:0]       nxt_imm;
    logic [31:0]       nxt_rs1;
    logic [31:0]       nxt_rs2;

    logic [31:0]       shadow [32];             // Register file as the writeback left it
    logic [31:0]       lfsr;
    logic [31:0]       pc_count;
    string             test_name;

    rv32i_decode_stage UUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_valid         (valid),
        .i_instr         (instr),
        .i_pc            (pc),
        .i_bubble        (bubble),
        .i_stall         (stall),
        .i_wb_we         (wb_we),
        .i_wb_addr       (wb_addr),
        .i_wb_data       (wb_data),
        .o_ex_valid      (ex_valid),
        .o_ex_pc         (ex_pc),
        .o_ex_cw         (ex_cw),
        .o_ex_branch_sel (ex_bsel),
        .o_ex_imm        (ex_imm),
        .o_ex_rs1_data   (ex_rs1),
        .o_ex_rs2_data   (ex_rs2)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string field, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Mismatch in %s, %s: expected %h, actual %h", test_name, field, exp_v, act_v);
        $display("RESULT: FAIL");
        $fatal(1, "output check failed");
    endtask

    a_valid: assert property (@(posedge clk) cur_chk |-> ex_valid == cur_valid)
        else report_mismatch("o_ex_valid", 32'($sampled(cur_valid)), 32'($sampled(ex_valid)));
    a_pc: assert property (@(posedge clk) cur_chk |-> ex_pc == cur_pc)
        else report_mismatch("o_ex_pc", $sampled(cur_pc), $sampled(ex_pc));
    a_cw: assert property (@(posedge clk) cur_chk |-> ex_cw == cur_cw)
        else report_mismatch("o_ex_cw", 32'($sampled(cur_cw)), 32'($sampled(ex_cw)));
    a_bsel: assert property (@(posedge clk) cur_chk |-> ex_bsel == cur_bsel)
        else report_mismatch("o_ex_branch_sel", 32'($sampled(cur_bsel)),
                             32'($sampled(ex_bsel)));
    a_imm: assert property (@(posedge clk) cur_chk |-> ex_imm == cur_imm)
        else report_mismatch("o_ex_imm", $sampled(cur_imm), $sampled(ex_imm));
    a_rs1: assert property (@(posedge clk) cur_chk |-> ex_rs1 == cur_rs1)
        else report_mismatch("o_ex_rs1_data", $sampled(cur_rs1), $sampled(ex_rs1));
    a_rs2: assert property (@(posedge clk) cur_chk |-> ex_rs2 == cur_rs2)
        else report_mismatch("o_ex_rs2_data", $sampled(cur_rs2), $sampled(ex_rs2));

    // Squashed slot carries no control and no valid
    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (bubble && !stall) |=> (ex_cw == '0 && ex_bsel == BR_NONE && !ex_valid))
        else report_mismatch("bubble squash", 32'd0,
                             {2'b00, $sampled(ex_cw), $sampled(ex_bsel), $sampled(ex_valid)});

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] with_opcode(input logic [6:0] opc);
        logic [31:0] bits;
        bits = take_bits(25);
        return {bits[24:0], opc};
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        logic [31:0] junk;
        junk = take_bits(7);
        case (sel)
            4'd0, 4'd9:  return OPC_OP;
            4'd1, 4'd10: return OPC_OP_IMM;
            4'd2, 4'd11: return OPC_LOAD;
            4'd3:        return OPC_JALR;
            4'd4, 4'd12: return OPC_STORE;
            4'd5, 4'd13: return OPC_BRANCH;
            4'd6:        return OPC_LUI;
            4'd7:        return OPC_AUIPC;
            4'd8:        return OPC_JAL;
            default:     return {junk[6:2], 1'b0, junk[0]};  // Bit 1 low is never RV32I
        endcase
    endfunction

    function automatic logic [3:0] alu_model(input logic [2:0] f3, input logic b30,
                                             input logic is_r);
        case (f3)
            3'd0:    return (is_r && b30) ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return b30 ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Flag nibble is {we, save_pc, load, use_immediate}
    function automatic logic [CW_W-1:0] model_cw(input logic [31:0] ins);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        f3  = ins[14:12];
        case (ins[6:0])
            OPC_OP:     return {rd, rs2, rs1, alu_model(f3, ins[30], 1'b1), 4'b1000, 3'd0};
            OPC_OP_IMM: return {rd, rs2, rs1, alu_model(f3, ins[30], 1'b0), 4'b1001, 3'd0};
            OPC_LOAD:   return {rd, rs2, rs1, ALU_ADD, 4'b1011, f3};
            OPC_JALR:   return {rd, rs2, rs1, ALU_ADD, 4'b1101, 3'd0};
            OPC_STORE:  return {5'd0, rs2, rs1, ALU_ADD, 4'b0001, f3};
            OPC_BRANCH: return {5'd0, rs2, rs1,
                                (f3 == 3'd6 || f3 == 3'd7) ? ALU_SLTU : ALU_SUB,  // BLTU, BGEU
                                4'b0000, 3'd0};
            OPC_LUI:    return {rd, rs2, 5'd0, ALU_ADD, 4'b1001, 3'd0};
            OPC_AUIPC:  return {rd, rs2, 5'd0, ALU_ADD, 4'b1101, 3'd0};
            OPC_JAL:    return {rd, rs2, 5'd0, ALU_ADD, 4'b1101, 3'd0};
            default:    return '0;
        endcase
    endfunction

    function automatic logic [2:0] model_branch(input logic [31:0] ins);
        if (ins[6:0] == OPC_JALR)
            return BR_JALR;
        if (ins[6:0] == OPC_JAL)
            return BR_JAL;
        if (ins[6:0] != OPC_BRANCH)
            return BR_NONE;
        case (ins[14:12])
            3'd0:       return BR_EQ;
            3'd1:       return BR_NE;
            3'd4, 3'd6: return BR_LT;
            3'd5, 3'd7: return BR_GE;
            default:    return BR_NONE;
        endcase
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] ins);
        logic [31:0] s;
        s = {32{ins[31]}};
        case (ins[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return {s[19:0], ins[31:20]};
            OPC_STORE:          return {s[19:0], ins[31:25], ins[11:7]};
            OPC_BRANCH:         return {s[19:0], ins[7], ins[30:25], ins[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: return {ins[31:12], 12'd0};
            OPC_JAL:            return {s[11:0], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:            return '0;
        endcase
    endfunction

    function automatic logic [31:0] read_model(input logic [4:0] ra, input logic we,
                                               input logic [4:0] wa, input logic [31:0] wd);
        if (ra == 5'd0)
            return '0;
        else if (we && ra == wa)
            return wd;                          // Same-edge writeback wins
        else
            return shadow[ra];
    endfunction

    task automatic step(input logic [31:0] ins, input logic vld, input logic bub,
                        input logic stl, input logic wwe, input logic [4:0] wad,
                        input logic [31:0] wdt);
        logic [CW_W-1:0] cw;
        @(negedge clk);
        cur_valid = nxt_valid;
        cur_pc    = nxt_pc;
        cur_cw    = nxt_cw;
        cur_bsel  = nxt_bsel;
        cur_imm   = nxt_imm;
        cur_rs1   = nxt_rs1;
        cur_rs2   = nxt_rs2;
        cur_chk   = 1'b1;
        instr     = ins;
        valid     = vld;
        bubble    = bub;
        stall     = stl;
        pc        = pc_count;
        wb_we     = wwe;
        wb_addr   = wad;
        wb_data   = wdt;
        if (!stl)
        begin
            cw        = bub ? '0 : model_cw(ins);
            nxt_valid = vld & ~bub;
            nxt_pc    = pc_count;
            nxt_cw    = cw;
            nxt_bsel  = bub ? BR_NONE : model_branch(ins);
            nxt_imm   = model_imm(ins);
            nxt_rs1   = read_model(cw[CW_ASEL_LSB +: REG_ADDR_W], wwe, wad, wdt);
            nxt_rs2   = read_model(cw[CW_BSEL_LSB +: REG_ADDR_W], wwe, wad, wdt);
        end
        if (wwe && wad != 5'd0)
            shadow[wad] = wdt;                  // Writes land even while stalled
        pc_count = pc_count + 32'd4;
    endtask

    task automatic issue(input logic [31:0] ins);
        step(ins, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        while (ex_valid !== 1'b1)
        begin
            if (n == limit)
            begin
                $display("Timeout in %s: o_ex_valid did not return after the bubble", test_name);
                $display("RESULT: FAIL");
                $fatal(1, "wait for valid timed out");
            end
            else
            begin
                issue(NOP_INSTR);
                n++;
            end
        end
    endtask

    initial
    begin
        logic [31:0] bits;
        logic [31:0] ins;
        lfsr      = 32'h5b03;
        rst_n     = 1'b0;
        valid     = 1'b0;
        instr     = '0;
        pc        = '0;
        bubble    = 1'b0;
        stall     = 1'b0;
        wb_we     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        pc_count  = 32'h0000_1000;
        cur_chk   = 1'b0;
        {cur_valid, cur_pc, cur_cw, cur_bsel, cur_imm, cur_rs1, cur_rs2} = '0;
        {nxt_valid, nxt_pc, nxt_cw, nxt_bsel, nxt_imm, nxt_rs1, nxt_rs2} = '0;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        test_name = "reset";
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_name = "regfile";
        for (int r = 1; r < 32; r++)
            step(NOP_INSTR, 1'b1, 1'b0, 1'b0, 1'b1, 5'(r), take_bits(32));
        for (int r = 1; r < 32; r++)
            issue({7'h00, 5'(32 - r), 5'(r), 3'd0, 5'd1, OPC_OP});
        step(NOP_INSTR, 1'b1, 1'b0, 1'b0, 1'b1, 5'd0, 32'hdead_beef);
        issue({7'h00, 5'd0, 5'd0, 3'd0, 5'd1, OPC_OP});        // x0 still reads zero
        step({7'h00, 5'd7, 5'd7, 3'd0, 5'd2, OPC_OP}, 1'b1, 1'b0, 1'b0, 1'b1, 5'd7,
             take_bits(32));

        test_name = "alu_ops";
        for (int f = 0; f < 16; f++)
        begin
            bits = take_bits(15);
            ins  = {(f[3] ? 7'h20 : 7'h00), bits[14:5], f[2:0], bits[4:0], OPC_OP};
            issue(ins);
            ins[6:0] = OPC_OP_IMM;              // Bit 30 kept, SUB must not follow
            issue(ins);
        end

        test_name = "mem_jump_upper";
        for (int f = 0; f < 8; f++)
        begin
            ins = with_opcode(OPC_LOAD);
            ins[14:12] = 3'(f);
            issue(ins);
            ins = with_opcode(OPC_STORE);
            ins[14:12] = 3'(f);
            issue(ins);
        end
        for (int k = 0; k < 4; k++)
        begin
            issue(with_opcode(OPC_JAL));
            issue(with_opcode(OPC_JALR));
            issue(with_opcode(OPC_LUI));
            issue(with_opcode(OPC_AUIPC));
            issue(with_opcode(pick_opcode(4'd15)));
        end

        test_name = "branches";
        for (int f = 0; f < 8; f++)
        begin
            ins = with_opcode(OPC_BRANCH);
            ins[14:12] = 3'(f);
            issue(ins);
        end

        test_name = "bubble";
        for (int k = 0; k < 4; k++)
        begin
            bits = take_bits(4);
            step(with_opcode(pick_opcode(bits[3:0])), 1'b1, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);
        end
        wait_for_valid(4);

        test_name = "stall";
        issue(with_opcode(OPC_OP));
        for (int k = 0; k < 3; k++)
            step(with_opcode(OPC_OP_IMM), 1'b1, 1'b0, 1'b1, 1'b1, 5'd9, take_bits(32));
        issue({7'h00, 5'd9, 5'd9, 3'd0, 5'd3, OPC_OP});        // Successor reads x9
        issue(NOP_INSTR);

        test_name = "random";
        for (int n = 0; n < 400; n++)
        begin
            bits = take_bits(16);
            ins  = with_opcode(pick_opcode(bits[3:0]));
            step(ins, bits[6:4] != 3'd0, bits[9:7] == 3'd7, bits[12:10] == 3'd0,
                 bits[13], 5'(take_bits(5)), take_bits(32));
        end
        issue(NOP_INSTR);
        issue(NOP_INSTR);
        @(negedge clk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule
